// File: cpuPkg.sv
package cpuPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] opR     = 7'b0110011;
    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010; // LW and SW width

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000; // SUB, SRA, SRAI

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra
    } aluOpT;

    typedef struct packed {
        logic [6:0]          funct7;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } rFieldsT;

    typedef struct packed {
        logic [11:0]         imm;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } iFieldsT;

    typedef struct packed {
        logic [6:0]          immHigh;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [4:0]          immLow;
        logic [6:0]          opcode;
    } sFieldsT;

    // Same 32 bits seen as R, I or S format
    typedef union packed {
        rFieldsT rView;
        iFieldsT iView;
        sFieldsT sView;
    } instrWordT;

endpackage

// File: ctrlPkg.sv
package ctrlPkg;

    // Idle is a separate busy flag, not a state
    typedef enum logic [1:0] {
        sFetch,
        sDecode,
        sExecute,
        sWriteback
    } stateT;

    typedef enum logic {
        srcReg, // rs2 operand register
        srcImm  // Immediate register
    } srcBSelT;

    typedef enum logic {
        immI,
        immS
    } immSelT;

    typedef enum logic {
        wbAlu,
        wbMem
    } wbSelT;

endpackage

// File: aluUnit.sv
`timescale 1ns/1ps

module aluUnit
    import cpuPkg::*;
(
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluOpT           aluOp,
    output logic [xlen-1:0] result
);
    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (aluOp)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSlt:  result = {{(xlen-1){1'b0}}, ltSigned};
            aluSltu: result = {{(xlen-1){1'b0}}, ltUnsigned};
            aluSll:  result = a << shamt;
            aluSrl:  result = a >> shamt;
            aluSra:  result = $signed(a) >>> shamt; // Sign fills from the top
            default: result = a + b;
        endcase
    end

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile
    import cpuPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic [regAddrW-1:0] rs1,
    input  logic [regAddrW-1:0] rs2,
    input  logic [regAddrW-1:0] rd,
    input  logic [xlen-1:0]     wrData,
    input  logic                regWrite,
    input  logic [regAddrW-1:0] dbgAddr,
    output logic [xlen-1:0]     rs1Data,
    output logic [xlen-1:0]     rs2Data,
    output logic [xlen-1:0]     dbgData
);
    localparam int depth = 2 ** regAddrW;

    logic [xlen-1:0] regs [depth];

    function automatic logic [xlen-1:0] readReg(input logic [regAddrW-1:0] addr);
        return (addr == '0) ? '0 : regs[addr]; // x0 hardwired
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rd != '0) begin
            regs[rd] <= wrData;
        end
    end

    assign rs1Data = readReg(rs1);
    assign rs2Data = readReg(rs2);
    assign dbgData = readReg(dbgAddr); // Testbench peek port

endmodule

// File: memArray.sv
`timescale 1ns/1ps

module memArray #(
    parameter int words = 64
) (
    input  logic        clk,
    input  logic        we,
    input  logic [31:0] wAddr,
    input  logic [31:0] wData,
    input  logic [31:0] rAddr,
    output logic [31:0] rData
);
    localparam int aW = (words > 1) ? $clog2(words) : 1;

    logic [31:0]   mem [words];
    logic [aW-1:0] wIdx;
    logic [aW-1:0] rIdx;

    // Word addresses wrap modulo the depth
    assign wIdx = aW'(wAddr % words);
    assign rIdx = aW'(rAddr % words);

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wIdx] <= wData;
        end
    end

    assign rData = mem[rIdx]; // Same-cycle read

endmodule

// File: instrCounter.sv
`timescale 1ns/1ps

module instrCounter #(
    parameter int cntW = 32
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            start,
    input  logic            busy,
    input  logic            retire,
    output logic [cntW-1:0] instrCount,
    output logic [cntW-1:0] cycleCount
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            instrCount <= '0;
            cycleCount <= '0;
        end else if (start) begin
            instrCount <= '0; // New run restarts both
            cycleCount <= '0;
        end else begin
            if (retire && instrCount != '1) begin
                instrCount <= instrCount + 1'b1; // Saturates at all ones
            end
            if (busy && cycleCount != '1) begin
                cycleCount <= cycleCount + 1'b1;
            end
        end
    end

endmodule

// File: controlFsm.sv
`timescale 1ns/1ps

module controlFsm
    import cpuPkg::*;
    import ctrlPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      start,
    input  instrWordT instr,
    output logic      busy,
    output logic      irLoad,
    output logic      opLoad,
    output logic      aluCapture,
    output logic      regWrite,
    output logic      memWrite,
    output logic      pcAdvance,
    output logic      retire,
    output aluOpT     aluOp,
    output srcBSelT   srcBSel,
    output immSelT    immSel,
    output wbSelT     wbSel
);
    stateT   state;
    aluOpT   decAluOp;
    srcBSelT decSrcB;
    immSelT  decImm;
    wbSelT   decWb;
    logic    decRegWr;
    logic    decMemWr;
    aluOpT   heldAluOp;
    srcBSelT heldSrcB;
    immSelT  heldImm;
    wbSelT   heldWb;
    logic    heldRegWr;
    logic    heldMemWr;
    logic    isHalt;
    logic    altFunct;
    logic    inWb;

    // Shared funct3 mapping for R-type and I-type ALU ops
    function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic subOk,
                                            input logic alt);
        case (f3)
            f3AddSub: return (subOk && alt) ? aluSub : aluAdd;
            f3Sll:    return aluSll;
            f3Slt:    return aluSlt;
            f3Sltu:   return aluSltu;
            f3Xor:    return aluXor;
            f3SrlSra: return alt ? aluSra : aluSrl;
            f3Or:     return aluOr;
            default:  return aluAnd;
        endcase
    endfunction

    assign isHalt   = (instr == '0);
    assign altFunct = (instr.rView.funct7 == f7Alt);

    always_comb begin
        decAluOp = aluAdd; // Address add for LW and SW
        decSrcB  = srcImm;
        decImm   = immI;
        decWb    = wbAlu;
        decRegWr = 1'b0;
        decMemWr = 1'b0;
        case (instr.rView.opcode)
            opR: begin
                decSrcB  = srcReg;
                decAluOp = aluFromFunct3(instr.rView.funct3, 1'b1, altFunct);
                decRegWr = (instr.rView.funct7 == f7Base) ||
                           (altFunct && (instr.rView.funct3 == f3AddSub ||
                                         instr.rView.funct3 == f3SrlSra));
            end
            opImm: begin
                decAluOp = aluFromFunct3(instr.iView.funct3, 1'b0, altFunct);
                decRegWr = 1'b1;
            end
            cpuPkg::opLoad: begin // Port opLoad hides the opcode name
                decWb    = wbMem;
                decRegWr = (instr.iView.funct3 == f3Word);
            end
            opStore: begin
                decImm   = immS;
                decMemWr = (instr.sView.funct3 == f3Word);
            end
            default: ; // Unsupported, retires with no write
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy      <= 1'b0;
            state     <= sFetch;
            heldAluOp <= aluAdd;
            heldSrcB  <= srcReg;
            heldImm   <= immI;
            heldWb    <= wbAlu;
            heldRegWr <= 1'b0;
            heldMemWr <= 1'b0;
        end else if (!busy) begin
            if (start) begin
                busy  <= 1'b1;
                state <= sFetch;
            end
        end else if (state == sDecode) begin
            heldAluOp <= decAluOp;
            heldSrcB  <= decSrcB;
            heldImm   <= decImm;
            heldWb    <= decWb;
            heldRegWr <= decRegWr;
            heldMemWr <= decMemWr;
            if (isHalt) begin
                busy  <= 1'b0; // Back to idle
                state <= sFetch;
            end else begin
                state <= sExecute;
            end
        end else begin
            state <= stateT'(state + 2'd1); // Writeback wraps to fetch
        end
    end

    assign irLoad     = busy && (state == sFetch);
    assign opLoad     = busy && (state == sDecode);
    assign aluCapture = busy && (state == sExecute);
    assign inWb       = busy && (state == sWriteback);
    assign regWrite   = inWb && heldRegWr;
    assign memWrite   = inWb && heldMemWr;
    assign pcAdvance  = inWb;
    assign retire     = inWb;

    // Decoded value in decode, held copy through writeback
    assign aluOp   = opLoad ? decAluOp : heldAluOp;
    assign srcBSel = opLoad ? decSrcB  : heldSrcB;
    assign immSel  = opLoad ? decImm   : heldImm;
    assign wbSel   = opLoad ? decWb    : heldWb;

endmodule

// File: datapath.sv
`timescale 1ns/1ps

module datapath
    import cpuPkg::*;
    import ctrlPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  logic                irLoad,
    input  logic                opLoad,
    input  logic                aluCapture,
    input  logic                regWrite,
    input  logic                pcAdvance,
    input  aluOpT               aluOp,
    input  srcBSelT             srcBSel,
    input  immSelT              immSel,
    input  wbSelT               wbSel,
    input  logic [xlen-1:0]     imemData,
    input  logic [xlen-1:0]     dmemRData,
    input  logic [regAddrW-1:0] dbgAddr,
    output instrWordT           instr,
    output logic [xlen-1:0]     imemAddr,
    output logic [xlen-1:0]     dmemAddr,
    output logic [xlen-1:0]     dmemWData,
    output logic [xlen-1:0]     dbgData
);
    logic [xlen-1:0] pc;
    logic [xlen-1:0] regA;
    logic [xlen-1:0] regB;
    logic [xlen-1:0] immReg;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] immIVal;
    logic [xlen-1:0] immSVal;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] wrData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (start) begin
            pc <= '0; // Programs start at word 0
        end else if (pcAdvance) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (irLoad) begin
            instr <= imemData;
        end
        if (opLoad) begin
            regA   <= rs1Data;
            regB   <= rs2Data;
            immReg <= (immSel == immS) ? immSVal : immIVal;
        end
        if (aluCapture) begin
            aluOut <= aluResult;
        end
    end

    // Sign-extended immediates
    assign immIVal = {{(xlen-12){instr.iView.imm[11]}}, instr.iView.imm};
    assign immSVal = {{(xlen-12){instr.sView.immHigh[6]}}, instr.sView.immHigh,
                      instr.sView.immLow};

    assign opB    = (srcBSel == srcImm) ? immReg : regB;
    assign wrData = (wbSel == wbMem) ? dmemRData : aluOut;

    regFile i_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1     (instr.rView.rs1),
        .rs2     (instr.rView.rs2),
        .rd      (instr.rView.rd),
        .wrData  (wrData),
        .regWrite(regWrite),
        .dbgAddr (dbgAddr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .dbgData (dbgData)
    );

    aluUnit i_aluUnit (
        .a     (regA),
        .b     (opB),
        .aluOp (aluOp),
        .result(aluResult)
    );

    // Byte addresses to word addresses
    assign imemAddr  = {2'b00, pc[xlen-1:2]};
    assign dmemAddr  = {2'b00, aluOut[xlen-1:2]};
    assign dmemWData = regB;

endmodule

// File: cpuTop.sv
`timescale 1ns/1ps

module cpuTop
    import cpuPkg::*;
    import ctrlPkg::*;
#(
    parameter int imemWords = 64,
    parameter int dmemWords = 64,
    parameter int cntW      = 32
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  logic                loadEn,
    input  logic [xlen-1:0]     loadAddr, // Word address
    input  logic [xlen-1:0]     loadData,
    input  logic [regAddrW-1:0] dbgAddr,
    output logic                busy,
    output logic [xlen-1:0]     dbgData,
    output logic [cntW-1:0]     instrCount,
    output logic [cntW-1:0]     cycleCount
);
    instrWordT       instr;
    logic            irLoad;
    logic            opLoad;
    logic            aluCapture;
    logic            regWrite;
    logic            memWrite;
    logic            pcAdvance;
    logic            retire;
    aluOpT           aluOp;
    srcBSelT         srcBSel;
    immSelT          immSel;
    wbSelT           wbSel;
    logic [xlen-1:0] imemAddr;
    logic [xlen-1:0] imemData;
    logic [xlen-1:0] dmemAddr;
    logic [xlen-1:0] dmemWData;
    logic [xlen-1:0] dmemRData;

    controlFsm i_controlFsm (
        .clk(clk), .rstN(rstN), .start(start), .instr(instr), .busy(busy),
        .irLoad(irLoad), .opLoad(opLoad), .aluCapture(aluCapture),
        .regWrite(regWrite), .memWrite(memWrite), .pcAdvance(pcAdvance),
        .retire(retire), .aluOp(aluOp), .srcBSel(srcBSel), .immSel(immSel),
        .wbSel(wbSel)
    );

    instrCounter #(.cntW(cntW)) i_instrCounter (
        .clk(clk), .rstN(rstN), .start(start), .busy(busy), .retire(retire),
        .instrCount(instrCount), .cycleCount(cycleCount)
    );

    datapath i_datapath (
        .clk(clk), .rstN(rstN), .start(start), .irLoad(irLoad), .opLoad(opLoad),
        .aluCapture(aluCapture), .regWrite(regWrite), .pcAdvance(pcAdvance),
        .aluOp(aluOp), .srcBSel(srcBSel), .immSel(immSel), .wbSel(wbSel),
        .imemData(imemData), .dmemRData(dmemRData), .dbgAddr(dbgAddr),
        .instr(instr), .imemAddr(imemAddr), .dmemAddr(dmemAddr),
        .dmemWData(dmemWData), .dbgData(dbgData)
    );

    // Written only by the load port
    memArray #(.words(imemWords)) iMem (
        .clk(clk), .we(loadEn), .wAddr(loadAddr), .wData(loadData),
        .rAddr(imemAddr), .rData(imemData)
    );

    memArray #(.words(dmemWords)) dMem (
        .clk(clk), .we(memWrite), .wAddr(dmemAddr), .wData(dmemWData),
        .rAddr(dmemAddr), .rData(dmemRData)
    );

endmodule

// File: cpuTop_checker.sv
`timescale 1ns/1ps

module fsmChecker
    import ctrlPkg::*;
(
    input logic  clk,
    input logic  rstN,
    input logic  start,
    input logic  busy,
    input stateT state,
    input logic  regWrite,
    input logic  memWrite
);
    stateT nextState;

    assign nextState = stateT'(state + 2'd1); // Writeback wraps to fetch

    // Strobes come two cycles after decode and never together
    writeInWb: assert property (@(posedge clk) disable iff (!rstN)
        (regWrite || memWrite) |->
            (state == sWriteback && $past(state, 2) == sDecode && !(regWrite && memWrite)))
        else $error("Write strobe outside writeback");

    // A halt word in decode drops busy instead of stepping
    stepByOne: assert property (@(posedge clk) disable iff (!rstN)
        busy |=> (!busy || state == $past(nextState)))
        else $error("State did not advance by one while busy");

    idleUntilStart: assert property (@(posedge clk) disable iff (!rstN)
        (!busy && !start) |=> !busy)
        else $error("Busy rose without a start pulse");

endmodule

bind controlFsm fsmChecker i_fsmChecker (
    .clk(clk), .rstN(rstN), .start(start), .busy(busy), .state(state),
    .regWrite(regWrite), .memWrite(memWrite)
);

// File: tb_cpuTop.sv
`timescale 1ns/1ps

module tb_cpuTop;

    localparam int clkPeriod = 8;
    localparam int maxWords  = 32; // Longest program, halt word excluded
    localparam int numRuns   = 5;
    localparam int runLimit  = 4 * maxWords + 4;
    localparam int perRun    = (maxWords + 2) + runLimit + 32;
    localparam int watchdogCycles = numRuns * perRun + 200;

    localparam logic [6:0] opRegOp   = 7'b0110011;
    localparam logic [6:0] opImmOp   = 7'b0010011;
    localparam logic [6:0] opLoadOp  = 7'b0000011;
    localparam logic [6:0] opStoreOp = 7'b0100011;

    logic        clk = 1'b0;
    logic        rstN;
    logic        start;
    logic        loadEn;
    logic [31:0] loadAddr;
    logic [31:0] loadData;
    logic [4:0]  dbgAddr;
    logic        busy;
    logic [31:0] dbgData;
    logic [31:0] instrCount;
    logic [31:0] cycleCount;

    logic [31:0] progMem [maxWords];
    int          progLen;
    logic [31:0] refRegs [32]; // Software model state
    logic [31:0] refMem [64];
    int          seed = 32'h879685b9;
    int          errors;
    int          testsRun;
    int          testsFailed;

    cpuTop i_dut (
        .clk(clk), .rstN(rstN), .start(start), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .dbgAddr(dbgAddr), .busy(busy), .dbgData(dbgData),
        .instrCount(instrCount), .cycleCount(cycleCount)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [11:0] randImm();
        return 12'($random(seed));
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opRegOp};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStoreOp};
    endfunction

    // RV32I result for one funct3, straight from the ISA rules
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic isR, input logic [31:0] a,
                                           input logic [31:0] b);
        case (f3)
            3'd0: return (isR && alt) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        if (progLen < maxWords) begin
            progMem[progLen] = word;
            progLen++;
        end else begin
            $display("Program is longer than %0d words", maxWords);
            errors++;
        end
    endtask

    // Wide random value, negative with forceNeg and non-negative without
    task automatic loadRandom(input logic [4:0] rd, input logic forceNeg);
        if (forceNeg) begin
            emit(encI(randImm(), 5'd0, 3'b000, rd, opImmOp));
            emit(encI(12'd20, rd, 3'b001, rd, opImmOp));
            emit(encI(randImm() | 12'h800, rd, 3'b110, rd, opImmOp)); // ORI fills the top
        end else begin
            emit(encI(randImm() & 12'h7ff, 5'd0, 3'b000, rd, opImmOp));
            emit(encI(12'd20, rd, 3'b001, rd, opImmOp));
            emit(encI(randImm() & 12'h7ff, rd, 3'b000, rd, opImmOp)); // Sign bit stays clear
        end
    endtask

    task automatic modelRun(output int n);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] immI;
        logic [31:0] immS;
        n = 0;
        for (int pc = 0; pc < progLen; pc++) begin
            w    = progMem[pc];
            a    = refRegs[w[19:15]];
            immI = {{20{w[31]}}, w[31:20]};
            immS = {{20{w[31]}}, w[31:25], w[11:7]};
            res  = 32'd0;
            case (w[6:0])
                opRegOp: res = aluRef(w[14:12], w[30], 1'b1, a, refRegs[w[24:20]]);
                opImmOp: res = aluRef(w[14:12], w[30], 1'b0, a, immI);
                opLoadOp: begin
                    addr = a + immI;
                    res  = refMem[addr[7:2]]; // 64-word data memory
                end
                opStoreOp: begin
                    addr = a + immS;
                    refMem[addr[7:2]] = refRegs[w[24:20]];
                end
                default: ;
            endcase
            if ((w[6:0] == opRegOp || w[6:0] == opImmOp || w[6:0] == opLoadOp) &&
                w[11:7] != 5'd0) refRegs[w[11:7]] = res;
            n++;
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i <= progLen; i++) begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = 32'(i);
            loadData = (i < progLen) ? progMem[i] : 32'd0; // Halt word last
        end
        @(negedge clk);
        loadEn = 1'b0;
    endtask

    task automatic runProgram();
        int waited;
        waited = 0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (!busy) begin
            $display("busy did not rise after the start pulse");
            errors++;
        end
        while (busy && waited < runLimit) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            $display("Program still running after %0d cycles", runLimit);
            errors++;
        end
    endtask

    task automatic checkRegs();
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            dbgAddr = 5'(i);
            #1;
            checkVal($sformatf("x%0d", i), refRegs[i], dbgData);
        end
    endtask

    task automatic runAndCompare();
        int n;
        loadProgram();
        modelRun(n);
        runProgram();
        checkRegs();
        checkVal("instrCount", 32'(n), instrCount);
        checkVal("cycleCount", 32'(4 * n + 2), cycleCount);
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testsRun++;
        if (errors == errorsBefore) begin
            $display("Test %s: passed", name);
        end else begin
            testsFailed++;
            $display("Test %s: failed with %0d errors", name, errors - errorsBefore);
        end
    endtask

    task automatic testReset();
        int e0;
        e0 = errors;
        checkVal("busy", 32'd0, {31'd0, busy});
        checkVal("instrCount", 32'd0, instrCount);
        checkVal("cycleCount", 32'd0, cycleCount);
        checkRegs();
        finishTest("reset", e0);
    endtask

    task automatic testImmAlu();
        int e0;
        e0 = errors;
        progLen = 0;
        loadRandom(5'd1, 1'b0);
        loadRandom(5'd2, 1'b1);
        emit(encI(randImm(), 5'd1, 3'b000, 5'd3, opImmOp)); // ADDI
        emit(encI(randImm(), 5'd1, 3'b111, 5'd4, opImmOp)); // ANDI
        emit(encI(randImm(), 5'd1, 3'b110, 5'd5, opImmOp));
        emit(encI(randImm(), 5'd1, 3'b100, 5'd6, opImmOp));
        emit(encI(randImm(), 5'd2, 3'b010, 5'd7, opImmOp)); // SLTI on negative
        emit(encI(randImm(), 5'd2, 3'b011, 5'd8, opImmOp));
        emit(encI(randImm(), 5'd1, 3'b010, 5'd12, opImmOp));
        emit(encI({7'd0, 5'(randImm())}, 5'd1, 3'b001, 5'd9, opImmOp));
        emit(encI({7'd0, 5'(randImm())}, 5'd2, 3'b101, 5'd10, opImmOp));
        emit(encI({7'b0100000, 5'(randImm()) | 5'd1}, 5'd2, 3'b101, 5'd11, opImmOp)); // SRAI
        runAndCompare();
        finishTest("I-type ALU", e0);
    endtask

    task automatic testRegAlu();
        int e0;
        e0 = errors;
        progLen = 0;
        loadRandom(5'd1, 1'b0);
        loadRandom(5'd2, 1'b0);
        loadRandom(5'd3, 1'b1);
        emit(encI(randImm() | 12'h001, 5'd0, 3'b000, 5'd4, opImmOp)); // Nonzero shift amount
        emit(encR(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd10)); // ADD
        emit(encR(7'b0100000, 5'd3, 5'd1, 3'b000, 5'd11)); // SUB
        emit(encR(7'b0000000, 5'd2, 5'd1, 3'b111, 5'd12));
        emit(encR(7'b0000000, 5'd3, 5'd1, 3'b110, 5'd13));
        emit(encR(7'b0000000, 5'd3, 5'd2, 3'b100, 5'd14));
        emit(encR(7'b0000000, 5'd1, 5'd3, 3'b010, 5'd15)); // SLT negative first
        emit(encR(7'b0000000, 5'd3, 5'd1, 3'b010, 5'd16));
        emit(encR(7'b0000000, 5'd1, 5'd3, 3'b011, 5'd17)); // SLTU sees it as large
        emit(encR(7'b0000000, 5'd3, 5'd1, 3'b011, 5'd18));
        emit(encR(7'b0000000, 5'd4, 5'd1, 3'b001, 5'd19));
        emit(encR(7'b0000000, 5'd4, 5'd3, 3'b101, 5'd20));
        emit(encR(7'b0100000, 5'd4, 5'd3, 3'b101, 5'd21)); // SRA of negative
        runAndCompare();
        finishTest("R-type ALU", e0);
    endtask

    task automatic testMemory();
        int e0;
        e0 = errors;
        progLen = 0;
        emit(encI(12'd16, 5'd0, 3'b000, 5'd1, opImmOp)); // Base address 16
        loadRandom(5'd2, 1'b0);
        loadRandom(5'd3, 1'b1);
        emit(encI(randImm(), 5'd0, 3'b000, 5'd4, opImmOp));
        emit(encS(12'd0, 5'd2, 5'd1));
        emit(encS(12'd12, 5'd3, 5'd1));
        emit(encS(12'd40, 5'd4, 5'd1));
        emit(encS(12'hffc, 5'd4, 5'd2 - 5'd1)); // x1 base, offset -4
        emit(encI(12'd0, 5'd1, 3'b010, 5'd5, opLoadOp));
        emit(encI(12'd12, 5'd1, 3'b010, 5'd6, opLoadOp));
        emit(encI(12'd40, 5'd1, 3'b010, 5'd7, opLoadOp));
        emit(encI(12'hffc, 5'd1, 3'b010, 5'd8, opLoadOp));
        emit(encI(12'd5, 5'd1, 3'b000, 5'd0, opImmOp)); // Writes aimed at x0
        emit(encR(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd0));
        emit(encI(12'd0, 5'd1, 3'b010, 5'd0, opLoadOp));
        runAndCompare();
        finishTest("memory and x0", e0);
    endtask

    task automatic testCounters();
        int e0;
        e0 = errors;
        progLen = 0;
        for (int i = 1; i <= 7; i++) emit(encI(randImm(), 5'd0, 3'b000, 5'(i), opImmOp));
        runAndCompare();
        progLen = 0;
        for (int i = 1; i <= 3; i++) emit(encI(randImm(), 5'(i), 3'b100, 5'(i), opImmOp));
        runAndCompare(); // Counts restart, not accumulate
        finishTest("counters and timing", e0);
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Watchdog expired after %0d cycles", watchdogCycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rstN     = 1'b0;
        start    = 1'b0;
        loadEn   = 1'b0;
        loadAddr = 32'd0;
        loadData = 32'd0;
        dbgAddr  = 5'd0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        progLen     = 0;
        for (int i = 0; i < 32; i++) refRegs[i] = 32'd0;
        for (int i = 0; i < 64; i++) refMem[i] = 32'd0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        testReset();
        testImmAlu();
        testRegAlu();
        testMemory();
        testCounters();
        $display("Summary: %0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sim.f
cpuPkg.sv
ctrlPkg.sv
aluUnit.sv
regFile.sv
memArray.sv
instrCounter.sv
controlFsm.sv
datapath.sv
cpuTop.sv
cpuTop_checker.sv
tb_cpuTop.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_cpuTop

out=$(./obj_dir/Vtb_cpuTop 2>&1) || true
echo "$out"

# The run passes only if the testbench printed its pass line
grep -qx "PASS: all tests" <<< "$out"
